// ==== inval_pkg.sv ====
// Sizes are fixed here; L1LineBytes, L1Sets and MaxTxns must be powers of two
package inval_pkg;

  ////////////////////////////////////////////////////////////
  // Bus and cache geometry
  ////////////////////////////////////////////////////////////

  // Byte address and W data widths
  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned DataWidth   = 32;

  // L1 line size in bytes and number of direct-mapped sets
  localparam int unsigned L1LineBytes = 16;
  localparam int unsigned L1Sets      = 16;

  // Outstanding write bursts held by the AW FIFO
  localparam int unsigned MaxTxns     = 4;

  // Address split, derived
  localparam int unsigned IdxWidth    = $clog2(L1Sets);
  localparam int unsigned OffWidth    = $clog2(L1LineBytes);
  localparam int unsigned TagWidth    = AddrWidth - IdxWidth - OffWidth;

  // FIFO pointer and fill-level widths
  localparam int unsigned FifoPtrWidth = $clog2(MaxTxns);
  localparam int unsigned FifoCntWidth = $clog2(MaxTxns + 1);

  ////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////

  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [7:0]              axi_len_t;
  typedef logic [2:0]              axi_size_t;
  typedef logic [1:0]              axi_resp_t;
  typedef logic [TagWidth-1:0]     tag_t;
  typedef logic [IdxWidth-1:0]     idx_t;
  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [DataWidth/8-1:0]  strb_t;
  typedef logic [FifoPtrWidth-1:0] fifo_ptr_t;
  typedef logic [FifoCntWidth-1:0] fifo_cnt_t;

  // Address step between two invalidated lines
  localparam addr_t LineStep = addr_t'(L1LineBytes);

endpackage

// ==== aw_chan_if.sv ====
// AW channel only, no id/burst/cache fields; bursts are assumed INCR
`timescale 1ns/1ps

interface aw_chan_if import inval_pkg::*; ();

  // Handshake
  logic      aw_valid;
  logic      aw_ready;

  // Payload, stable while aw_valid waits for aw_ready
  addr_t     aw_addr;
  axi_len_t  aw_len;
  axi_size_t aw_size;

  // Receiving side of the channel
  modport slv (
    input  aw_valid,
    output aw_ready,
    input  aw_addr,
    input  aw_len,
    input  aw_size
  );

  // Issuing side of the channel
  modport mst (
    output aw_valid,
    input  aw_ready,
    output aw_addr,
    output aw_len,
    output aw_size
  );

endinterface

// ==== inval_aw_fifo.sv ====
// Fall-through FIFO of MaxTxns entries; push when full or pop when empty is illegal
`timescale 1ns/1ps

module inval_aw_fifo import inval_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      push_i,
  input  addr_t     data_addr_i,
  input  axi_len_t  data_len_i,
  input  axi_size_t data_size_i,
  input  logic      pop_i,
  output logic      full_o,
  output logic      empty_o,
  output addr_t     data_addr_o,
  output axi_len_t  data_len_o,
  output axi_size_t data_size_o
);

  // Storage, no reset needed on payload
  addr_t     addr_mem [MaxTxns];
  axi_len_t  len_mem  [MaxTxns];
  axi_size_t size_mem [MaxTxns];

  fifo_ptr_t wr_ptr_q, rd_ptr_q;
  fifo_cnt_t cnt_q;
  logic      bypass;
  logic      wr_en, rd_en;

  // Wrapping pointer increment
  function automatic fifo_ptr_t ptr_inc(input fifo_ptr_t ptr);
    if (ptr == fifo_ptr_t'(MaxTxns - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Empty FIFO with push and pop together: entry goes straight through
  assign bypass = push_i & pop_i & (cnt_q == '0);
  assign wr_en  = push_i & ~bypass & (~full_o | pop_i);
  assign rd_en  = pop_i & (cnt_q != '0);

  assign full_o  = (cnt_q == fifo_cnt_t'(MaxTxns));
  // Incoming push makes the head visible this cycle
  assign empty_o = (cnt_q == '0) & ~push_i;

  // Head of queue, or the input itself when empty
  assign data_addr_o = (cnt_q == '0) ? data_addr_i : addr_mem[rd_ptr_q];
  assign data_len_o  = (cnt_q == '0) ? data_len_i  : len_mem[rd_ptr_q];
  assign data_size_o = (cnt_q == '0) ? data_size_i : size_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      addr_mem[wr_ptr_q] <= data_addr_i;
      len_mem[wr_ptr_q]  <= data_len_i;
      size_mem[wr_ptr_q] <= data_size_i;
    end
  end

  // Pointers and fill level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (rd_en) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (wr_en && !rd_en) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!wr_en && rd_en) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Producer must respect full unless the consumer frees a slot
  assert property (@(posedge clk_i) disable iff (!rst_ni) (push_i && full_o) |-> pop_i);

  // Consumer only pops what it can see
  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o);

endmodule

// ==== axi_inval_filter.sv ====
// INCR bursts only; span is (len+1+misaligned)<<size; at least one line per burst
`timescale 1ns/1ps

module axi_inval_filter import inval_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          en_i,
  aw_chan_if.slv        slv_aw,
  aw_chan_if.mst        mst_aw,
  output addr_t         inval_addr_o,
  output logic          inval_valid_o,
  input  logic          inval_ready_i
);

  typedef enum logic {
    Idle,
    Invalidating
  } filter_state_e;

  filter_state_e state_d, state_q;

  // Queue side
  logic      fifo_full, fifo_empty;
  logic      fifo_push, fifo_pop;
  addr_t     fifo_addr;
  axi_len_t  fifo_len;
  axi_size_t fifo_size;

  // Walk through the burst
  addr_t     offset_d, offset_q;
  addr_t     span;
  logic      misaligned;

  ////////////////////////////////////////////////////////////
  // AW forwarding
  ////////////////////////////////////////////////////////////

  // Payload passes untouched
  assign mst_aw.aw_addr = slv_aw.aw_addr;
  assign mst_aw.aw_len  = slv_aw.aw_len;
  assign mst_aw.aw_size = slv_aw.aw_size;

  // No new burst while the queue has no room
  assign mst_aw.aw_valid = slv_aw.aw_valid & ~fifo_full;
  assign slv_aw.aw_ready = mst_aw.aw_ready & ~fifo_full;

  // Record every accepted burst while snooping is on
  assign fifo_push = en_i & slv_aw.aw_valid & slv_aw.aw_ready;

  inval_aw_fifo i_aw_fifo (
    .clk_i       ( clk_i          ),
    .rst_ni      ( rst_ni         ),
    .push_i      ( fifo_push      ),
    .data_addr_i ( slv_aw.aw_addr ),
    .data_len_i  ( slv_aw.aw_len  ),
    .data_size_i ( slv_aw.aw_size ),
    .pop_i       ( fifo_pop       ),
    .full_o      ( fifo_full      ),
    .empty_o     ( fifo_empty     ),
    .data_addr_o ( fifo_addr      ),
    .data_len_o  ( fifo_len       ),
    .data_size_o ( fifo_size      )
  );

  ////////////////////////////////////////////////////////////
  // Line invalidation FSM
  ////////////////////////////////////////////////////////////

  // Extra beat when the start sits inside a line
  assign misaligned = |fifo_addr[OffWidth-1:0];
  assign span = (addr_t'(fifo_len) + addr_t'(1) + addr_t'(misaligned)) << fifo_size;

  assign inval_addr_o  = fifo_addr + offset_q;
  assign inval_valid_o = ~fifo_empty;

  always_comb begin
    state_d  = state_q;
    offset_d = offset_q;
    fifo_pop = 1'b0;

    unique case (state_q)
      Idle: begin
        // First line of a burst accepted by the tag array
        if (!fifo_empty && inval_ready_i) begin
          if (LineStep < span) begin
            state_d  = Invalidating;
            offset_d = LineStep;
          end else begin
            fifo_pop = 1'b1;
          end
        end
      end
      Invalidating: begin
        if (inval_ready_i) begin
          offset_d = offset_q + LineStep;
          // Drop the burst once its last line is covered
          if (offset_d >= span) begin
            state_d  = Idle;
            offset_d = '0;
            fifo_pop = 1'b1;
          end
        end
      end
      default: begin
        state_d  = Idle;
        offset_d = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= Idle;
      offset_q <= '0;
    end else begin
      state_q  <= state_d;
      offset_q <= offset_d;
    end
  end

  // Request held steady across tag array back-pressure
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (inval_valid_o && !inval_ready_i) |=> (inval_valid_o && $stable(inval_addr_o)));

  // Invalidating only with a burst still queued and a line already issued
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == Invalidating) |-> (!fifo_empty && offset_q != '0));

endmodule

// ==== l1_tag_array.sv ====
// Direct-mapped tags and valid bits only without data; fill blocks invalidation that cycle
`timescale 1ns/1ps

module l1_tag_array import inval_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  // Fill port without handshake
  input  logic  fill_valid_i,
  input  addr_t fill_addr_i,
  // Combinational lookup port
  input  addr_t lookup_addr_i,
  output logic  lookup_hit_o,
  // Invalidation port
  input  addr_t inval_addr_i,
  input  logic  inval_valid_i,
  output logic  inval_ready_o
);

  // Per-set state
  logic [L1Sets-1:0] valid_q;
  tag_t              tag_q [L1Sets];

  // Address fields
  idx_t fill_idx, lookup_idx, inval_idx;
  tag_t fill_tag, lookup_tag, inval_tag;

  logic inval_fire;
  logic inval_match;

  assign fill_idx   = fill_addr_i[OffWidth +: IdxWidth];
  assign fill_tag   = fill_addr_i[AddrWidth-1 -: TagWidth];
  assign lookup_idx = lookup_addr_i[OffWidth +: IdxWidth];
  assign lookup_tag = lookup_addr_i[AddrWidth-1 -: TagWidth];
  assign inval_idx  = inval_addr_i[OffWidth +: IdxWidth];
  assign inval_tag  = inval_addr_i[AddrWidth-1 -: TagWidth];

  ////////////////////////////////////////////////////////////
  // Port arbitration
  ////////////////////////////////////////////////////////////

  // Fill has priority over invalidation
  assign inval_ready_o = ~fill_valid_i;
  assign inval_fire    = inval_valid_i & inval_ready_o;

  // Only a line holding the snooped tag is dropped
  assign inval_match = valid_q[inval_idx] & (tag_q[inval_idx] == inval_tag);

  // Hit on the current register state
  assign lookup_hit_o = valid_q[lookup_idx] & (tag_q[lookup_idx] == lookup_tag);

  ////////////////////////////////////////////////////////////
  // Storage update
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (fill_valid_i) begin
      tag_q[fill_idx] <= fill_tag;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (fill_valid_i) begin
      valid_q[fill_idx] <= 1'b1;
    end else if (inval_fire && inval_match) begin
      valid_q[inval_idx] <= 1'b0;
    end
  end

endmodule

// ==== inval_top.sv ====
// AW snooped for invalidation; W and B are wires; AR and R are not part of this block
`timescale 1ns/1ps

module inval_top import inval_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      en_i,

  // Slave side, from the write master
  input  logic      slv_aw_valid_i,
  output logic      slv_aw_ready_o,
  input  addr_t     slv_aw_addr_i,
  input  axi_len_t  slv_aw_len_i,
  input  axi_size_t slv_aw_size_i,
  input  logic      slv_w_valid_i,
  output logic      slv_w_ready_o,
  input  data_t     slv_w_data_i,
  input  strb_t     slv_w_strb_i,
  input  logic      slv_w_last_i,
  output logic      slv_b_valid_o,
  input  logic      slv_b_ready_i,
  output axi_resp_t slv_b_resp_o,

  // Master side, toward memory
  output logic      mst_aw_valid_o,
  input  logic      mst_aw_ready_i,
  output addr_t     mst_aw_addr_o,
  output axi_len_t  mst_aw_len_o,
  output axi_size_t mst_aw_size_o,
  output logic      mst_w_valid_o,
  input  logic      mst_w_ready_i,
  output data_t     mst_w_data_o,
  output strb_t     mst_w_strb_o,
  output logic      mst_w_last_o,
  input  logic      mst_b_valid_i,
  output logic      mst_b_ready_o,
  input  axi_resp_t mst_b_resp_i,

  // Cache side
  input  logic      fill_valid_i,
  input  addr_t     fill_addr_i,
  input  addr_t     lookup_addr_i,
  output logic      lookup_hit_o
);

  aw_chan_if slv_aw ();
  aw_chan_if mst_aw ();

  // Filter to tag array link
  addr_t inval_addr;
  logic  inval_valid;
  logic  inval_ready;

  ////////////////////////////////////////////////////////////
  // Port mapping
  ////////////////////////////////////////////////////////////

  assign slv_aw.aw_valid = slv_aw_valid_i;
  assign slv_aw.aw_addr  = slv_aw_addr_i;
  assign slv_aw.aw_len   = slv_aw_len_i;
  assign slv_aw.aw_size  = slv_aw_size_i;
  assign slv_aw_ready_o  = slv_aw.aw_ready;

  assign mst_aw_valid_o  = mst_aw.aw_valid;
  assign mst_aw_addr_o   = mst_aw.aw_addr;
  assign mst_aw_len_o    = mst_aw.aw_len;
  assign mst_aw_size_o   = mst_aw.aw_size;
  assign mst_aw.aw_ready = mst_aw_ready_i;

  // W forward, zero latency
  assign mst_w_valid_o = slv_w_valid_i;
  assign mst_w_data_o  = slv_w_data_i;
  assign mst_w_strb_o  = slv_w_strb_i;
  assign mst_w_last_o  = slv_w_last_i;
  assign slv_w_ready_o = mst_w_ready_i;

  // B backward, zero latency
  assign slv_b_valid_o = mst_b_valid_i;
  assign slv_b_resp_o  = mst_b_resp_i;
  assign mst_b_ready_o = slv_b_ready_i;

  axi_inval_filter i_filter (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .en_i          ( en_i        ),
    .slv_aw        ( slv_aw      ),
    .mst_aw        ( mst_aw      ),
    .inval_addr_o  ( inval_addr  ),
    .inval_valid_o ( inval_valid ),
    .inval_ready_i ( inval_ready )
  );

  l1_tag_array i_tags (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .fill_valid_i  ( fill_valid_i  ),
    .fill_addr_i   ( fill_addr_i   ),
    .lookup_addr_i ( lookup_addr_i ),
    .lookup_hit_o  ( lookup_hit_o  ),
    .inval_addr_i  ( inval_addr    ),
    .inval_valid_i ( inval_valid   ),
    .inval_ready_o ( inval_ready   )
  );

endmodule

// ==== tb_inval_top.sv ====
// Testbench drives inputs 1 ns after the rising edge; lookups assume fill is idle when checked
`timescale 1ns/1ps

module tb_inval_top import inval_pkg::*; ();

  // Rough cycle budget per test
  // Watchdog allows twice the sum plus margin
  localparam int unsigned TestCycles = 60 + 80 + 200 + 100 + 160;
  localparam int unsigned WatchdogNs = (2 * TestCycles + 400) * 8;

  logic clk = 1'b0;
  logic rst_n;
  logic en;
  logic slv_aw_valid, slv_aw_ready_o, slv_w_valid, slv_w_ready_o, slv_w_last, slv_b_ready;
  addr_t slv_aw_addr;
  axi_len_t slv_aw_len;
  axi_size_t slv_aw_size;
  data_t slv_w_data;
  strb_t slv_w_strb;
  logic slv_b_valid_o, mst_aw_valid_o, mst_aw_ready, mst_w_valid_o, mst_w_ready, mst_w_last_o;
  axi_resp_t slv_b_resp_o, mst_b_resp;
  addr_t mst_aw_addr_o;
  axi_len_t mst_aw_len_o;
  axi_size_t mst_aw_size_o;
  data_t mst_w_data_o;
  strb_t mst_w_strb_o;
  logic mst_b_valid, mst_b_ready_o;
  logic fill_valid, lookup_hit_o;
  addr_t fill_addr, lookup_addr;

  // Expectations that the assertions compare against
  logic lookup_chk, lookup_exp, stall_chk, en_off_chk;
  int unsigned fail_cnt, tests_run, lookups_run;

  always #4 clk = ~clk;

  inval_top i_inval_top (
    .clk_i (clk), .rst_ni (rst_n), .en_i (en),
    .slv_aw_valid_i (slv_aw_valid), .slv_aw_ready_o (slv_aw_ready_o),
    .slv_aw_addr_i (slv_aw_addr), .slv_aw_len_i (slv_aw_len), .slv_aw_size_i (slv_aw_size),
    .slv_w_valid_i (slv_w_valid), .slv_w_ready_o (slv_w_ready_o), .slv_w_data_i (slv_w_data),
    .slv_w_strb_i (slv_w_strb), .slv_w_last_i (slv_w_last),
    .slv_b_valid_o (slv_b_valid_o), .slv_b_ready_i (slv_b_ready), .slv_b_resp_o (slv_b_resp_o),
    .mst_aw_valid_o (mst_aw_valid_o), .mst_aw_ready_i (mst_aw_ready),
    .mst_aw_addr_o (mst_aw_addr_o), .mst_aw_len_o (mst_aw_len_o),
    .mst_aw_size_o (mst_aw_size_o),
    .mst_w_valid_o (mst_w_valid_o), .mst_w_ready_i (mst_w_ready), .mst_w_data_o (mst_w_data_o),
    .mst_w_strb_o (mst_w_strb_o), .mst_w_last_o (mst_w_last_o),
    .mst_b_valid_i (mst_b_valid), .mst_b_ready_o (mst_b_ready_o), .mst_b_resp_i (mst_b_resp),
    .fill_valid_i (fill_valid), .fill_addr_i (fill_addr),
    .lookup_addr_i (lookup_addr), .lookup_hit_o (lookup_hit_o)
  );

  ////////////////////////////////////////////////////////////
  // Checking assertions
  ////////////////////////////////////////////////////////////

  // AW payload forwarded untouched
  assert property (@(posedge clk) disable iff (!rst_n) mst_aw_valid_o |-> (slv_aw_valid &&
    mst_aw_addr_o == slv_aw_addr && mst_aw_len_o == slv_aw_len && mst_aw_size_o == slv_aw_size))
  else begin
    fail_cnt = fail_cnt + 1;
    $display("CHECK FAILED at %0t: mst AW differs from slv AW", $time);
  end

  // Ready follows downstream unless a full FIFO gates both sides
  assert property (@(posedge clk) disable iff (!rst_n)
    (slv_aw_ready_o == mst_aw_ready) || (!slv_aw_ready_o && !mst_aw_valid_o))
  else begin
    fail_cnt = fail_cnt + 1;
    $display("CHECK FAILED at %0t: AW ready not forwarded", $time);
  end

  // W and B are same-cycle wires
  assert property (@(posedge clk) disable iff (!rst_n)
    mst_w_valid_o == slv_w_valid && mst_w_data_o == slv_w_data && mst_w_strb_o == slv_w_strb &&
    mst_w_last_o == slv_w_last && slv_w_ready_o == mst_w_ready && slv_b_valid_o == mst_b_valid &&
    slv_b_resp_o == mst_b_resp && mst_b_ready_o == slv_b_ready)
  else begin
    fail_cnt = fail_cnt + 1;
    $display("CHECK FAILED at %0t: W or B passthrough mismatch", $time);
  end

  assert property (@(posedge clk) disable iff (!rst_n) lookup_chk |-> lookup_hit_o == lookup_exp)
  else begin
    fail_cnt = fail_cnt + 1;
    $display("CHECK FAILED at %0t: lookup of %h expected hit=%0b",
             $time, lookup_addr, lookup_exp);
  end

  // Full FIFO holds AW on both sides
  assert property (@(posedge clk) disable iff (!rst_n)
    stall_chk |-> !slv_aw_ready_o && !mst_aw_valid_o)
  else begin
    fail_cnt = fail_cnt + 1;
    $display("CHECK FAILED at %0t: AW not stalled with full FIFO", $time);
  end

  // Snooping off never stalls AW
  assert property (@(posedge clk) disable iff (!rst_n)
    en_off_chk |-> slv_aw_ready_o == mst_aw_ready)
  else begin
    fail_cnt = fail_cnt + 1;
    $display("CHECK FAILED at %0t: AW stalled while snooping disabled", $time);
  end

  ////////////////////////////////////////////////////////////
  // AXI slave model and watchdog
  ////////////////////////////////////////////////////////////

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  initial begin
    logic [31:0] lfsr;
    int unsigned b_pending;
    logic w_done, b_done;
    lfsr = 32'h6dbe_49cc;
    b_pending = 0;
    mst_aw_ready = 1'b0;
    mst_w_ready = 1'b0;
    mst_b_valid = 1'b0;
    mst_b_resp = '0;
    forever begin
      // Handshakes are settled well before the edge
      @(negedge clk);
      w_done = mst_w_valid_o & mst_w_ready & mst_w_last_o;
      b_done = mst_b_valid & mst_b_ready_o;
      @(posedge clk);
      #1;
      if (w_done) b_pending = b_pending + 1;
      if (b_done) b_pending = b_pending - 1;
      lfsr = lfsr_next(lfsr);
      mst_aw_ready = lfsr[0];
      lfsr = lfsr_next(lfsr);
      mst_w_ready = lfsr[0];
      // New response code only once the previous one is taken
      if (b_done || !mst_b_valid) begin
        lfsr = lfsr_next(lfsr);
        mst_b_resp = {lfsr[0], 1'b0};
      end
      mst_b_valid = (b_pending != 0);
    end
  end

  initial begin
    #(WatchdogNs);
    $display("Timeout: run did not finish within %0d ns", WatchdogNs);
    $display("Checks failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  // Beat count plus one when misaligned, shifted by size and rounded up to whole lines
  function automatic int unsigned lines_for(input addr_t a, input axi_len_t l, input axi_size_t s);
    int unsigned beats;
    int unsigned bytes;
    beats = 32'(l) + 32'd1;
    if (a[OffWidth-1:0] != '0) beats = beats + 1;
    bytes = beats << s;
    return (bytes + L1LineBytes - 1) / L1LineBytes;
  endfunction

  task automatic fill_line(input addr_t a);
    fill_valid = 1'b1;
    fill_addr = a;
    @(posedge clk);
    #1;
    fill_valid = 1'b0;
  endtask

  task automatic check_line(input addr_t a, input logic exp_hit);
    lookup_addr = a;
    lookup_exp = exp_hit;
    lookup_chk = 1'b1;
    @(posedge clk);
    #1;
    lookup_chk = 1'b0;
    lookups_run = lookups_run + 1;
  endtask

  task automatic send_aw(input addr_t a, input axi_len_t l, input axi_size_t s);
    logic done;
    done = 1'b0;
    slv_aw_valid = 1'b1;
    slv_aw_addr = a;
    slv_aw_len = l;
    slv_aw_size = s;
    while (!done) begin
      @(negedge clk);
      done = slv_aw_ready_o;
      @(posedge clk);
      #1;
    end
    slv_aw_valid = 1'b0;
  endtask

  task automatic send_w(input addr_t a, input int unsigned beats);
    logic done;
    for (int unsigned i = 0; i < beats; i++) begin
      done = 1'b0;
      slv_w_valid = 1'b1;
      slv_w_data = a ^ data_t'(i);
      slv_w_strb = strb_t'(i) | strb_t'(1);
      slv_w_last = (i == beats - 1);
      while (!done) begin
        @(negedge clk);
        done = slv_w_ready_o;
        @(posedge clk);
        #1;
      end
    end
    slv_w_valid = 1'b0;
    slv_w_last = 1'b0;
  endtask

  task automatic wait_b();
    logic done;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = slv_b_valid_o;
      @(posedge clk);
      #1;
    end
  endtask

  // Sequence of AW, exact invalidation wait, W data and B response
  task automatic write_burst(input addr_t a, input axi_len_t l, input axi_size_t s);
    send_aw(a, l, s);
    repeat (lines_for(a, l, s) + 2) @(posedge clk);
    #1;
    send_w(a, 32'(l) + 32'd1);
    wait_b();
  endtask

  task automatic report_test(input string name, input int unsigned fails_before);
    tests_run = tests_run + 1;
    $display("%0t ns  %-22s %s", $time, name, (fail_cnt == fails_before) ? "pass" : "fail");
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic passthrough_bursts();
    int unsigned f0;
    f0 = fail_cnt;
    write_burst(32'h0000_1000, 8'd3, 3'd2);
    write_burst(32'h0000_2004, 8'd0, 3'd1);
    report_test("passthrough", f0);
  endtask

  task automatic single_line_inval();
    int unsigned f0;
    f0 = fail_cnt;
    fill_line(32'h0001_0010);
    fill_line(32'h0002_0020);
    write_burst(32'h0001_0010, 8'd0, 3'd2);
    check_line(32'h0001_0010, 1'b0);
    check_line(32'h0002_0020, 1'b1);
    report_test("single line", f0);
  endtask

  task automatic multi_line_inval();
    int unsigned f0;
    int unsigned n;
    f0 = fail_cnt;
    for (int unsigned pass = 0; pass < 2; pass++) begin
      // Aligned start first, then four bytes into the first line
      for (int unsigned i = 0; i < 3; i++) fill_line(32'h0003_0040 + addr_t'(i * L1LineBytes));
      n = lines_for(32'h0003_0040 + addr_t'(pass * 4), 8'd7, 3'd2);
      write_burst(32'h0003_0040 + addr_t'(pass * 4), 8'd7, 3'd2);
      for (int unsigned i = 0; i < 3; i++) begin
        check_line(32'h0003_0040 + addr_t'(i * L1LineBytes), i >= n);
      end
    end
    report_test("multi line", f0);
  endtask

  task automatic snoop_disabled();
    int unsigned f0;
    f0 = fail_cnt;
    en = 1'b0;
    en_off_chk = 1'b1;
    fill_line(32'h0004_0080);
    fill_line(32'h0004_0090);
    write_burst(32'h0004_0080, 8'd7, 3'd2);
    write_burst(32'h0004_0094, 8'd0, 3'd2);
    check_line(32'h0004_0080, 1'b1);
    check_line(32'h0004_0090, 1'b1);
    en_off_chk = 1'b0;
    en = 1'b1;
    report_test("enable off", f0);
  endtask

  task automatic fifo_backpressure();
    int unsigned f0;
    int unsigned total;
    f0 = fail_cnt;
    total = 0;
    for (int unsigned i = 0; i < 5; i++) fill_line(32'h0005_00a0 + addr_t'(i * L1LineBytes));
    // Fill held on set 15 blocks every invalidation
    fill_valid = 1'b1;
    fill_addr = 32'h0005_00f0;
    for (int unsigned i = 0; i < MaxTxns; i++) begin
      send_aw(32'h0005_00a0 + addr_t'(i * L1LineBytes), 8'd0, 3'd2);
    end
    slv_aw_valid = 1'b1;
    slv_aw_addr = 32'h0005_00e0;
    slv_aw_len = 8'd0;
    slv_aw_size = 3'd2;
    stall_chk = 1'b1;
    repeat (2 * MaxTxns) @(posedge clk);
    #1;
    stall_chk = 1'b0;
    fill_valid = 1'b0;
    send_aw(32'h0005_00e0, 8'd0, 3'd2);
    for (int unsigned i = 0; i < 5; i++) begin
      total = total + lines_for(32'h0005_00a0 + addr_t'(i * L1LineBytes), 8'd0, 3'd2);
    end
    repeat (total + 2) @(posedge clk);
    #1;
    // One response per burst, taken before the next data beat
    for (int unsigned i = 0; i < 5; i++) begin
      send_w(32'h0005_00a0 + addr_t'(i * L1LineBytes), 1);
      wait_b();
    end
    for (int unsigned i = 0; i < 5; i++) begin
      check_line(32'h0005_00a0 + addr_t'(i * L1LineBytes), 1'b0);
    end
    check_line(32'h0005_00f0, 1'b1);
    report_test("back-pressure", f0);
  endtask

  initial begin
    rst_n = 1'b0;
    en = 1'b1;
    slv_aw_valid = 1'b0;
    slv_aw_addr = '0;
    slv_aw_len = '0;
    slv_aw_size = '0;
    slv_w_valid = 1'b0;
    slv_w_data = '0;
    slv_w_strb = '0;
    slv_w_last = 1'b0;
    slv_b_ready = 1'b1;
    fill_valid = 1'b0;
    fill_addr = '0;
    lookup_addr = '0;
    lookup_chk = 1'b0;
    lookup_exp = 1'b0;
    stall_chk = 1'b0;
    en_off_chk = 1'b0;
    fail_cnt = 0;
    tests_run = 0;
    lookups_run = 0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    passthrough_bursts();
    single_line_inval();
    multi_line_inval();
    snoop_disabled();
    fifo_backpressure();
    $display("Tests run: %0d, lookups checked: %0d, failures: %0d",
             tests_run, lookups_run, fail_cnt);
    if (fail_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
inval_pkg.sv
aw_chan_if.sv
inval_aw_fifo.sv
axi_inval_filter.sv
l1_tag_array.sv
inval_top.sv
tb_inval_top.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tb_inval_top -f all.f -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || echo "Build or simulation step returned an error"
cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log && exit 0 || exit 1
